// File: project.f
hw/cpu_pkg.sv
hw/fetch.sv
hw/control_unit.sv
hw/sign_extend.sv
hw/reg_file.sv
hw/decode.sv
hw/execute.sv
hw/cpu_top.sv
tb/tb_clock.sv
tb/tb_cpu.sv

// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f project.f --top-module tb_cpu -Mdir obj_dir

run: build
	./obj_dir/Vtb_cpu | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module tb_cpu

clean:
	rm -rf obj_dir $(LOG)

// File: tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int prog_size   = 64;
    localparam int retire_goal = 200;
    localparam int num_tests   = 6;

    logic               clk;
    logic               reset;
    logic               restart;
    logic               ins_req;
    logic [31:0]        ins_addr;
    logic               ins_ack;
    logic [31:0]        ins_data;
    cpu_pkg::wb_t       retire;

    logic [31:0] mem [0:prog_size-1];
    logic [31:0] lfsr;
    logic [31:0] mregs [0:31];     // ISA model state
    logic [31:0] mpc;
    logic        busy;
    logic [1:0]  cnt;
    logic [1:0]  delay;
    logic        prev_req;
    logic        prev_ack;
    logic [31:0] prev_addr;
    int          hs_errors;
    int          total_errors;
    int          failed_tests;

    tb_clock i_clock (.restart(restart), .clk(clk), .reset(reset));

    cpu_top i_dut (
        .clk     (clk),
        .reset   (reset),
        .ins_req (ins_req),
        .ins_addr(ins_addr),
        .ins_ack (ins_ack),
        .ins_data(ins_data),
        .retire  (retire)
    );

    // Fibonacci LFSR on taps 32 22 2 1 stepped once per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Instruction memory responder with an ack delay of 0 to 3 cycles
    always @(posedge clk) begin
        prev_req  <= ins_req;
        prev_ack  <= ins_ack;
        prev_addr <= ins_addr;
        if (!reset && ins_req && !prev_req && prev_ack) begin
            $display("handshake violation: ins_req rose before ins_ack fell");
            hs_errors++;
        end
        if (!reset && ins_req && prev_req && ins_addr != prev_addr) begin
            $display("handshake violation: ins_addr changed while ins_req was held");
            hs_errors++;
        end
        if (reset) begin
            ins_ack <= 1'b0;
            busy    <= 1'b0;
        end else if (ins_ack) begin
            if (!ins_req)
                ins_ack <= 1'b0;
        end else if (ins_req) begin
            if (!busy) begin
                delay = 2'(rand_bits(2));
                if (delay == 2'd0) begin
                    ins_ack  <= 1'b1;
                    ins_data <= mem[(ins_addr >> 2) % prog_size];
                end else begin
                    busy <= 1'b1;
                    cnt  <= delay - 2'd1;
                end
            end else if (cnt == 2'd0) begin
                busy     <= 1'b0;
                ins_ack  <= 1'b1;
                ins_data <= mem[(ins_addr >> 2) % prog_size];
            end else begin
                cnt <= cnt - 2'd1;
            end
        end
    end

    function automatic logic [4:0] pick_reg(input int mode);
        if (mode == 2)
            return 5'(rand_bits(2));          // Few registers for dense dependencies
        if (mode == 4 && rand_bits(2) == 0)
            return 5'd0;
        return 5'(rand_bits(5));
    endfunction

    task automatic gen_program(input int mode);
        logic [2:0]  k;
        logic [2:0]  f3;
        logic [1:0]  f;
        logic [5:0]  t;
        logic [12:0] off;
        logic        alt;
        for (int w = 1; w < 32; w++)          // Prologue of ADDI xw, x0, imm
            mem[w-1] = {12'(rand_bits(12)), 5'd0, 3'b000, 5'(w), 7'h13};
        for (int w = 31; w < prog_size; w++) begin
            k   = 3'(rand_bits(3));
            f3  = 3'(rand_bits(3));
            alt = 1'(rand_bits(1)) && (f3 == 3'b000 || f3 == 3'b101);
            if (mode == 0 || (mode == 2 && k[0]) || (mode == 3 && k > 5) || (mode == 5 && k < 3))
                mem[w] = {1'b0, alt, 5'd0, pick_reg(mode), pick_reg(mode), f3,
                          pick_reg(mode), 7'h33};
            else if ((mode == 3 && k < 3) || (mode == 5 && k > 5)) begin
                f   = 2'(rand_bits(2));
                t   = 6'(rand_bits(6));
                if (t == 6'(w))
                    t = t + 6'd1;
                off = 13'((int'(t) - w) * 4);
                mem[w] = {off[12], off[10:5], pick_reg(mode), pick_reg(mode),
                          f[1], 1'b0, f[0], off[4:1], off[11], 7'h63};
            end else if ((mode == 4 && k < 4) || (mode == 5 && k == 5))
                mem[w] = {20'(rand_bits(20)), pick_reg(mode), k[0] ? 7'h37 : 7'h17};
            else if (f3 == 3'b001 || f3 == 3'b101)  // Shift by immediate
                mem[w] = {1'b0, f3 == 3'b101 && 1'(rand_bits(1)), 5'd0, 5'(rand_bits(5)),
                          pick_reg(mode), f3, pick_reg(mode), 7'h13};
            else
                mem[w] = {12'(rand_bits(12)), pick_reg(mode), f3, pick_reg(mode), 7'h13};
        end
    endtask

    // Steps the ISA model once and returns the expected retire beat
    task automatic model_step(output logic [31:0] epc, output logic ewr,
                              output logic [4:0] erd, output logic [31:0] eval);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immb;
        logic        take;
        ins  = mem[(mpc >> 2) % prog_size];
        a    = mregs[ins[19:15]];
        b    = (ins[6:0] == 7'h13) ? {{20{ins[31]}}, ins[31:20]} : mregs[ins[24:20]];
        immb = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        epc  = mpc;
        erd  = ins[11:7];
        ewr  = 1'b1;
        eval = '0;
        take = 1'b0;
        case (ins[6:0])
            7'h37: eval = {ins[31:12], 12'd0};
            7'h17: eval = mpc + {ins[31:12], 12'd0};
            7'h63: begin
                ewr = 1'b0;
                case (ins[14:12])
                    3'b000:  take = a == mregs[ins[24:20]];
                    3'b001:  take = a != mregs[ins[24:20]];
                    3'b100:  take = $signed(a) < $signed(mregs[ins[24:20]]);
                    default: take = $signed(a) >= $signed(mregs[ins[24:20]]);
                endcase
            end
            default: begin
                case (ins[14:12])
                    3'b000:  eval = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
                    3'b001:  eval = a << b[4:0];
                    3'b010:  eval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011:  eval = (a < b) ? 32'd1 : 32'd0;
                    3'b100:  eval = a ^ b;
                    3'b101:  eval = ins[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110:  eval = a | b;
                    default: eval = a & b;
                endcase
            end
        endcase
        if (ewr && erd != 5'd0)
            mregs[erd] = eval;
        mpc = take ? mpc + immb : mpc + 32'd4;
    endtask

    task automatic run_test(input string name, input int mode, input bit first);
        logic [31:0] epc;
        logic [31:0] eval;
        logic [4:0]  erd;
        logic        ewr;
        int          count;
        int          errs;
        int          hs_start;
        count    = 0;
        errs     = 0;
        hs_start = hs_errors;
        if (!first) begin
            @(posedge clk) restart <= 1'b1;
            @(posedge clk) restart <= 1'b0;
        end
        @(negedge clk);
        while (!reset) @(negedge clk);
        gen_program(mode);                   // Pipeline is held in reset here
        for (int r = 0; r < 32; r++)
            mregs[r] = '0;
        mpc = '0;
        while (reset) @(negedge clk);
        while (count < retire_goal) begin
            @(negedge clk);
            if (retire.valid) begin
                model_step(epc, ewr, erd, eval);
                if (retire.pc != epc) begin
                    $display("ERROR %s: pc expected %h actual %h", name, epc, retire.pc);
                    errs++;
                end
                if (retire.reg_write != ewr) begin
                    $display("ERROR %s: reg_write expected %b actual %b at pc %h",
                             name, ewr, retire.reg_write, epc);
                    errs++;
                end
                if (ewr && (retire.rd != erd || retire.data != eval)) begin
                    $display("ERROR %s: x%0d=%h expected, x%0d=%h actual at pc %h",
                             name, erd, eval, retire.rd, retire.data, epc);
                    errs++;
                end
                count++;
            end
        end
        errs += hs_errors - hs_start;
        if (errs == 0)
            $display("test %s: ok, %0d retirements", name, count);
        else
            $display("test %s: failed with %0d mismatches", name, errs);
        total_errors += errs;
        if (errs != 0)
            failed_tests++;
    endtask

    // Watchdog sized from the retirement count of all tests
    initial begin
        #(longint'(num_tests) * retire_goal * 12 * 20 + 20000);
        $display("run timed out waiting for retirements");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        lfsr         = 32'h64a4_73cb;
        restart      <= 1'b0;
        ins_ack      <= 1'b0;
        ins_data     <= '0;
        busy         <= 1'b0;
        cnt          <= '0;
        hs_errors    = 0;
        total_errors = 0;
        failed_tests = 0;
        run_test("alu_reg", 0, 1'b1);
        run_test("alu_imm", 1, 1'b0);
        run_test("forwarding", 2, 1'b0);
        run_test("branches", 3, 1'b0);
        run_test("upper_x0", 4, 1'b0);
        run_test("mixed", 5, 1'b0);
        $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests, total_errors);
        if (total_errors == 0 && hs_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    input  logic restart,   // Re-assert reset for a new test
    output logic clk,
    output logic reset
);

    logic [1:0] cnt;

    initial begin
        clk   = 1'b0;
        reset <= 1'b1;
        cnt   <= 2'd2;
    end

    always #10 clk = ~clk;   // 20 ns period

    always @(posedge clk) begin
        if (restart) begin
            reset <= 1'b1;
            cnt   <= 2'd2;
        end else if (cnt != 2'd0) begin
            reset <= (cnt > 2'd1);   // Two edges in reset
            cnt   <= cnt - 2'd1;
        end
    end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                     clk,
    input  logic                     reset,
    output logic                     ins_req,
    output logic [cpu_pkg::xlen-1:0] ins_addr,
    input  logic                     ins_ack,
    input  logic [cpu_pkg::xlen-1:0] ins_data,
    output cpu_pkg::wb_t             retire
);

    cpu_pkg::if_id_t          if_id;
    cpu_pkg::id_ex_t          id_bundle;
    cpu_pkg::wb_t             wb;
    logic                     redirect;
    logic [cpu_pkg::xlen-1:0] redirect_pc;

    fetch fetch (
        .clk        (clk),
        .reset      (reset),
        .ins_req    (ins_req),
        .ins_addr   (ins_addr),
        .ins_ack    (ins_ack),
        .ins_data   (ins_data),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .if_id      (if_id)
    );

    decode decode (
        .clk      (clk),
        .if_id    (if_id),
        .wb       (wb),
        .id_bundle(id_bundle)
    );

    execute execute (
        .clk        (clk),
        .reset      (reset),
        .id_bundle  (id_bundle),
        .wb         (wb),
        .redirect   (redirect),
        .redirect_pc(redirect_pc)
    );

    assign retire = wb;   // Every writeback beat is a retirement

endmodule

// File: hw/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_pkg::id_ex_t          id_bundle,
    output cpu_pkg::wb_t             wb,
    output logic                     redirect,
    output logic [cpu_pkg::xlen-1:0] redirect_pc
);

    cpu_pkg::id_ex_t          ex;        // ID/EX register
    logic [cpu_pkg::xlen-1:0] rs1_val;
    logic [cpu_pkg::xlen-1:0] rs2_val;
    logic [cpu_pkg::xlen-1:0] op_a;
    logic [cpu_pkg::xlen-1:0] op_b;
    logic [cpu_pkg::xlen-1:0] result;
    logic                     cond;

    always_ff @(posedge clk) begin
        ex <= id_bundle;
        if (reset || redirect)
            ex.valid <= 1'b0;                  // Drop the fall-through slot
    end

    // Bypass from EX/WB for distance-1 dependencies
    function automatic logic fwd_hit(input logic [cpu_pkg::reg_addr_w-1:0] rs);
        return wb.valid && wb.reg_write && wb.rd != '0 && wb.rd == rs;
    endfunction

    assign rs1_val = fwd_hit(ex.rs1) ? wb.data : ex.rs1_data;
    assign rs2_val = fwd_hit(ex.rs2) ? wb.data : ex.rs2_data;

    assign op_a = (ex.ctrl.src_a == cpu_pkg::src_a_pc) ? ex.pc : rs1_val;
    assign op_b = ex.ctrl.src_b_imm ? ex.imm : rs2_val;

    always_comb begin
        case (ex.ctrl.alu_op)
            cpu_pkg::alu_sub:    result = op_a - op_b;
            cpu_pkg::alu_sll:    result = op_a << op_b[4:0];
            cpu_pkg::alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::alu_sltu:   result = {31'b0, op_a < op_b};
            cpu_pkg::alu_xor:    result = op_a ^ op_b;
            cpu_pkg::alu_srl:    result = op_a >> op_b[4:0];
            cpu_pkg::alu_sra:    result = $signed(op_a) >>> op_b[4:0];
            cpu_pkg::alu_or:     result = op_a | op_b;
            cpu_pkg::alu_and:    result = op_a & op_b;
            cpu_pkg::alu_pass_b: result = op_b;         // LUI
            default:             result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ex.ctrl.branch_op)
            cpu_pkg::br_eq: cond = rs1_val == rs2_val;
            cpu_pkg::br_ne: cond = rs1_val != rs2_val;
            cpu_pkg::br_lt: cond = $signed(rs1_val) < $signed(rs2_val);
            cpu_pkg::br_ge: cond = $signed(rs1_val) >= $signed(rs2_val);
            default:        cond = 1'b0;
        endcase
    end

    assign redirect    = ex.valid && cond;
    assign redirect_pc = ex.pc + ex.imm;

    always_ff @(posedge clk) begin
        if (reset)
            wb.valid <= 1'b0;
        else
            wb.valid <= ex.valid;
        wb.pc        <= ex.pc;
        wb.rd        <= ex.rd;
        wb.data      <= result;
        wb.reg_write <= ex.ctrl.reg_write;   // Low for branches
    end

endmodule

// File: hw/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic             clk,
    input  cpu_pkg::if_id_t  if_id,
    input  cpu_pkg::wb_t     wb,          // Register file write port
    output cpu_pkg::id_ex_t  id_bundle
);

    cpu_pkg::ctrl_t                 ctrl;
    logic [cpu_pkg::xlen-1:0]       imm;
    logic [cpu_pkg::xlen-1:0]       rs1_data;
    logic [cpu_pkg::xlen-1:0]       rs2_data;
    logic [cpu_pkg::reg_addr_w-1:0] rs1;
    logic [cpu_pkg::reg_addr_w-1:0] rs2;
    logic [cpu_pkg::reg_addr_w-1:0] rd;

    assign rs1 = if_id.ins[19:15];
    assign rs2 = if_id.ins[24:20];
    assign rd  = if_id.ins[11:7];

    control_unit control_unit (
        .instruction(if_id.ins),
        .ctrl       (ctrl)
    );

    sign_extend sign_extend (
        .imm_type  (ctrl.imm_type),
        .instr_imm (if_id.ins[31:7]),
        .imm_extend(imm)
    );

    reg_file reg_file (
        .clk       (clk),
        .read_addr1(rs1),
        .read_addr2(rs2),
        .write_addr(wb.rd),
        .write_en  (wb.valid && wb.reg_write),
        .write_data(wb.data),
        .data1     (rs1_data),
        .data2     (rs2_data)
    );

    always_comb begin
        id_bundle.valid    = if_id.valid;
        id_bundle.pc       = if_id.pc;
        id_bundle.rs1_data = rs1_data;
        id_bundle.rs2_data = rs2_data;
        id_bundle.imm      = imm;
        id_bundle.rs1      = rs1;
        id_bundle.rs2      = rs2;
        id_bundle.rd       = rd;
        id_bundle.ctrl     = ctrl;
    end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic [cpu_pkg::reg_addr_w-1:0] read_addr1,
    input  logic [cpu_pkg::reg_addr_w-1:0] read_addr2,
    input  logic [cpu_pkg::reg_addr_w-1:0] write_addr,
    input  logic                           write_en,
    input  logic [cpu_pkg::xlen-1:0]       write_data,
    output logic [cpu_pkg::xlen-1:0]       data1,
    output logic [cpu_pkg::xlen-1:0]       data2
);

    logic [cpu_pkg::xlen-1:0] regs [1:31];   // x0 not stored

    always_ff @(posedge clk) begin
        if (write_en && write_addr != '0)
            regs[write_addr] <= write_data;
    end

    // Write-through so decode sees a same-cycle writeback
    always_comb begin
        if (read_addr1 == '0)                              data1 = '0;
        else if (write_en && write_addr == read_addr1)     data1 = write_data;
        else                                               data1 = regs[read_addr1];
        if (read_addr2 == '0)                              data2 = '0;
        else if (write_en && write_addr == read_addr2)     data2 = write_data;
        else                                               data2 = regs[read_addr2];
    end

endmodule

// File: hw/sign_extend.sv
`timescale 1ns/1ps

module sign_extend (
    input  cpu_pkg::imm_type_e       imm_type,
    input  logic [24:0]              instr_imm,   // Instruction bits 31:7
    output logic [cpu_pkg::xlen-1:0] imm_extend
);

    // Index k here is instruction bit k+7
    always_comb begin
        case (imm_type)
            cpu_pkg::imm_b:
                imm_extend = {{19{instr_imm[24]}}, instr_imm[24], instr_imm[0],
                              instr_imm[23:18], instr_imm[4:1], 1'b0};
            cpu_pkg::imm_u:
                imm_extend = {instr_imm[24:5], 12'b0};
            default:                                  // I-type
                imm_extend = {{20{instr_imm[24]}}, instr_imm[24:13]};
        endcase
    end

endmodule

// File: hw/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic [cpu_pkg::xlen-1:0] instruction,
    output cpu_pkg::ctrl_t           ctrl
);

    logic [2:0] funct3;
    logic       funct7_b5;

    assign funct3    = instruction[14:12];
    assign funct7_b5 = instruction[30];

    // Shared funct3 table for OP and OP_IMM
    function automatic cpu_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            3'b001:  return cpu_pkg::alu_sll;
            3'b010:  return cpu_pkg::alu_slt;
            3'b011:  return cpu_pkg::alu_sltu;
            3'b100:  return cpu_pkg::alu_xor;
            3'b101:  return alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
            3'b110:  return cpu_pkg::alu_or;
            default: return cpu_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        // Defaults make an unknown opcode a no-op
        ctrl.alu_op    = cpu_pkg::alu_add;
        ctrl.src_a     = cpu_pkg::src_a_rs1;
        ctrl.src_b_imm = 1'b0;
        ctrl.imm_type  = cpu_pkg::imm_i;
        ctrl.branch_op = cpu_pkg::br_none;
        ctrl.reg_write = 1'b0;
        case (cpu_pkg::opcode_e'(instruction[6:0]))
            cpu_pkg::opc_op: begin
                ctrl.alu_op    = alu_from_funct(funct3, funct7_b5);
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::opc_op_imm: begin
                // Only the shift-right form reads funct7 here since ADDI has no SUB
                ctrl.alu_op    = alu_from_funct(funct3, funct7_b5 && funct3 == 3'b101);
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::opc_lui: begin
                ctrl.alu_op    = cpu_pkg::alu_pass_b;
                ctrl.src_b_imm = 1'b1;
                ctrl.imm_type  = cpu_pkg::imm_u;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::opc_auipc: begin
                ctrl.src_a     = cpu_pkg::src_a_pc;
                ctrl.src_b_imm = 1'b1;
                ctrl.imm_type  = cpu_pkg::imm_u;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::opc_branch: begin
                ctrl.imm_type = cpu_pkg::imm_b;
                case (funct3)
                    3'b000:  ctrl.branch_op = cpu_pkg::br_eq;
                    3'b001:  ctrl.branch_op = cpu_pkg::br_ne;
                    3'b100:  ctrl.branch_op = cpu_pkg::br_lt;
                    3'b101:  ctrl.branch_op = cpu_pkg::br_ge;
                    default: ctrl.branch_op = cpu_pkg::br_none;  // BLTU/BGEU unsupported
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: hw/fetch.sv
`timescale 1ns/1ps

module fetch (
    input  logic                     clk,
    input  logic                     reset,
    output logic                     ins_req,
    output logic [cpu_pkg::xlen-1:0] ins_addr,
    input  logic                     ins_ack,
    input  logic [cpu_pkg::xlen-1:0] ins_data,
    input  logic                     redirect,
    input  logic [cpu_pkg::xlen-1:0] redirect_pc,
    output cpu_pkg::if_id_t          if_id
);

    cpu_pkg::fetch_state_e    state;
    logic [cpu_pkg::xlen-1:0] pc;   // Address of the next request

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= cpu_pkg::fs_idle;
            ins_req     <= 1'b0;
            pc          <= '0;
            if_id.valid <= 1'b0;
        end else begin
            if_id.valid <= 1'b0;                // One-cycle pulse per fetch
            if (redirect)
                pc <= redirect_pc;
            case (state)
                cpu_pkg::fs_idle: begin
                    // Wait for the previous ack to fall before a new request
                    if (!ins_ack && !redirect) begin
                        ins_req  <= 1'b1;
                        ins_addr <= pc;
                        state    <= cpu_pkg::fs_wait_ack;
                    end
                end
                cpu_pkg::fs_wait_ack: begin
                    if (ins_ack) begin
                        ins_req <= 1'b0;
                        state   <= cpu_pkg::fs_idle;
                        if (!redirect) begin    // Squashed when a branch resolves now
                            if_id.valid <= 1'b1;
                            if_id.pc    <= ins_addr;
                            if_id.ins   <= ins_data;
                            pc          <= pc + cpu_pkg::xlen'(4);
                        end
                    end else if (redirect) begin
                        state <= cpu_pkg::fs_wait_drop;  // Finish handshake, then discard
                    end
                end
                cpu_pkg::fs_wait_drop: begin
                    if (ins_ack) begin
                        ins_req <= 1'b0;
                        state   <= cpu_pkg::fs_idle;
                    end
                end
                default: state <= cpu_pkg::fs_idle;
            endcase
        end
    end

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // RV32I major opcodes in use
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {imm_i, imm_b, imm_u} imm_type_e;

    typedef enum logic [2:0] {br_none, br_eq, br_ne, br_lt, br_ge} branch_op_e;

    typedef enum logic {src_a_rs1, src_a_pc} src_a_e;

    typedef enum logic [1:0] {fs_idle, fs_wait_ack, fs_wait_drop} fetch_state_e;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] ins;
    } if_id_t;

    typedef struct packed {
        alu_op_e    alu_op;
        src_a_e     src_a;
        logic       src_b_imm;   // Immediate replaces rs2
        imm_type_e  imm_type;
        branch_op_e branch_op;
        logic       reg_write;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic                  reg_write;
    } wb_t;

endpackage
